// File: test/pe_patterns.txt
# columns: inst din_n din_s din_w din_e din_lsu exp_n exp_s exp_w exp_e exp_lsu (hex)
# first data line is the number of patterns, in decimal
23
000000000000 a5a5a5a5 00000001 00000002 00000003 00000004 a5a5a5a5 a5a5a5a5 a5a5a5a5 a5a5a5a5 a5a5a5a5
8830456705af 10101010 20202020 30303030 40404040 50505050 00000000 00000000 00000000 00000000 4b4b4b4a
08014756940c 00000100 00000023 77777777 88888888 cafef00d 10101010 30303030 20202020 40404040 40404040
180145672490 00001000 00000001 deadbeef 12345678 ffffffff cafef00d 00000000 40404040 30303030 00000123
180145679240 00000000 00000001 0badf00d 55555555 99999999 cafef00d 00000000 40404040 30303030 00000fff
280101230000 80000001 00000003 0000000a 0000000b 0000000c 80000001 00000003 0000000a 0000000b ffffffff
380101230000 f0f0ff00 3c3c0ff0 00000001 00000002 00000003 f0f0ff00 3c3c0ff0 00000001 00000002 80000003
480101230000 f0f0ff00 3c3c0ff0 00000004 00000005 00000006 f0f0ff00 3c3c0ff0 00000004 00000005 30300f00
580101230000 f0f0ff00 3c3c0ff0 00000007 00000008 00000009 f0f0ff00 3c3c0ff0 00000007 00000008 fcfcfff0
680101230000 00000003 00000024 00000011 00000022 00000033 00000003 00000024 00000011 00000022 ccccf0f0
780101230000 80000000 0000001f 00000044 00000055 00000066 80000000 0000001f 00000044 00000055 00000030
880101230000 13579bdf ffffffff 00000001 00000002 00000003 13579bdf ffffffff 00000001 00000002 00000001
980101230000 00000005 ffffffff 0000000a 0000000b 0000000c 00000005 ffffffff 0000000a 0000000b 13579bdf
980101230000 ffffffff 00000005 0000000d 0000000e 0000000f ffffffff 00000005 0000000d 0000000e 00000001
080101230000 00000007 00000008 00000001 00000002 00000003 00000007 00000008 00000001 00000002 00000000
f80101230000 12345678 00000001 00000004 00000005 00000006 12345678 00000001 00000004 00000005 0000000f
088101230000 00000001 00000010 00000002 00000003 00000004 00000001 00000010 00000002 00000003 00000000
088101230000 00000001 00000020 00000002 00000003 00000004 00000001 00000020 00000002 00000003 00000010
088101230000 00000001 00000030 00000002 00000003 00000004 00000001 00000030 00000002 00000003 00000030
088101230000 00000001 00000040 00000002 00000003 00000004 00000001 00000040 00000002 00000003 00000060
08de9c6f0000 11111111 22222222 33333333 44444444 55555555 00000000 00000000 40404040 00000000 000000a0
182347b30000 00000000 00000000 00000100 00000001 00000000 cafef00d 30303030 00000000 00000001 00000000
880080610000 abcdef01 00c0ffee 00000000 00000000 00000000 000000ff abcdef01 40404040 00c0ffee 000000ff

// File: all.f
rtl/pe_pkg.sv
rtl/pe_reg_file.sv
rtl/pe_fu.sv
rtl/pe_crossbar.sv
rtl/pe.sv
test/pe_chk.sv
test/tb_pe.sv

// File: run.sh
#!/bin/sh
# build and run tb_pe with Verilator, the verdict comes from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_pe -f all.f -o tb_pe \
    && ./obj_dir/tb_pe | tee sim.log \
    || echo "build or simulation stopped with an error"
grep -q "^Simulation passed$" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: test/tb_pe.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pe;
    import pe_pkg::*;

    localparam int    data_w       = 32;
    localparam int    rst_cycles   = 8;
    localparam int    rst_timeout  = 40;  // cycles
    localparam string pattern_path = "test/pe_patterns.txt";

    logic              clk;
    logic              rst_n;
    logic [inst_w-1:0] inst;
    logic [data_w-1:0] din_n, din_s, din_w, din_e, din_lsu;
    logic [data_w-1:0] dout_n, dout_s, dout_w, dout_e, dout_lsu;

    logic [inst_w-1:0] p_inst;
    logic [data_w-1:0] p_din [5];
    logic [data_w-1:0] p_exp [5];
    int                seed;
    int                fd;
    int                n_patterns;
    string             text;

    pe #(.data_w(data_w)) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (inst),
        .din_n    (din_n),
        .din_s    (din_s),
        .din_w    (din_w),
        .din_e    (din_e),
        .din_lsu  (din_lsu),
        .dout_n   (dout_n),
        .dout_s   (dout_s),
        .dout_w   (dout_w),
        .dout_e   (dout_e),
        .dout_lsu (dout_lsu)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    task automatic end_with_failure(input string why);
        if (why != "") $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_data(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            end_with_failure("");
        end
    endtask

    task automatic check_reset(input string name, input logic [data_w-1:0] got);
        if (got !== '0) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got,
                     {data_w{1'b0}});
            end_with_failure("");
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < rst_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) end_with_failure("reset was never released");
    endtask

    // skips comment and blank lines
    task automatic next_data_line(output string line);
        string raw;
        int    got;
        line = "";
        while (line == "") begin
            got = $fgets(raw, fd);
            if (got == 0) begin
                end_with_failure("pattern file ended before all patterns were read");
            end else if (raw.len() > 1 && raw.getc(0) != "#") begin
                line = raw;
            end
        end
    endtask

    initial begin
        seed    = 86;
        inst    = 48'h8080_0000_0000;  // pass_a of fu, keeps the reset value
        din_n   = '0;
        din_s   = '0;
        din_w   = '0;
        din_e   = '0;
        din_lsu = '0;
        fd = $fopen(pattern_path, "r");
        if (fd == 0) end_with_failure("could not open the pattern file");

        wait_reset_release();

        // n,s,w,e show r0..r3, lsu shows the fu result
        #1;
        inst    = 48'h0888_4567_0000;
        din_n   = 32'h0000_0011;
        din_s   = 32'h0000_0022;
        din_w   = 32'h0000_0033;
        din_e   = 32'h0000_0044;
        din_lsu = 32'h0000_0055;
        #8;
        check_reset("dout_n", dout_n);
        check_reset("dout_s", dout_s);
        check_reset("dout_w", dout_w);
        check_reset("dout_e", dout_e);
        check_reset("dout_lsu", dout_lsu);

        next_data_line(text);
        if ($sscanf(text, "%d", n_patterns) != 1) end_with_failure("pattern count is unreadable");

        for (int k = 0; k < n_patterns; k++) begin
            next_data_line(text);
            if ($sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h", p_inst,
                        p_din[0], p_din[1], p_din[2], p_din[3], p_din[4],
                        p_exp[0], p_exp[1], p_exp[2], p_exp[3], p_exp[4]) != 11) begin
                end_with_failure($sformatf("pattern %0d has missing fields", k + 1));
            end
            @(posedge clk);
            #1;
            inst    = p_inst;
            din_n   = p_din[0];
            din_s   = p_din[1];
            din_w   = p_din[2];
            din_e   = p_din[3];
            din_lsu = p_din[4];
            #8;  // just before the next edge
            check_data("dout_n", dout_n, p_exp[0]);
            check_data("dout_s", dout_s, p_exp[1]);
            check_data("dout_w", dout_w, p_exp[2]);
            check_data("dout_e", dout_e, p_exp[3]);
            check_data("dout_lsu", dout_lsu, p_exp[4]);
        end

        $fclose(fd);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/pe_chk.sv
`timescale 1ns/10ps
`default_nettype none

module pe_chk #(
    parameter int data_w = 32
) (
    input wire              clk,
    input wire              rst_n,
    input wire [3:0]        we,
    input wire [data_w-1:0] r0,
    input wire [data_w-1:0] r1,
    input wire [data_w-1:0] r2,
    input wire [data_w-1:0] r3
);

    // cleared in the cycle after reset
    a_reset_clear: assert property (@(posedge clk)
        !rst_n |=> (r0 == '0 && r1 == '0 && r2 == '0 && r3 == '0))
        else $error("registers not cleared after reset");

    a_hold_r0: assert property (@(posedge clk) disable iff (!rst_n) !we[3] |=> $stable(r0))
        else $error("r0 changed with its write enable low");
    a_hold_r1: assert property (@(posedge clk) disable iff (!rst_n) !we[2] |=> $stable(r1))
        else $error("r1 changed with its write enable low");
    a_hold_r2: assert property (@(posedge clk) disable iff (!rst_n) !we[1] |=> $stable(r2))
        else $error("r2 changed with its write enable low");
    a_hold_r3: assert property (@(posedge clk) disable iff (!rst_n) !we[0] |=> $stable(r3))
        else $error("r3 changed with its write enable low");

endmodule

bind pe_reg_file pe_chk #(.data_w(data_w)) u_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (we),
    .r0    (r0),
    .r1    (r1),
    .r2    (r2),
    .r3    (r3)
);

`default_nettype wire

// File: rtl/pe.sv
`timescale 1ns/10ps
`default_nettype none

module pe #(
    parameter int data_w = 32
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire [pe_pkg::inst_w-1:0]   inst,
    input  wire [data_w-1:0]           din_n,
    input  wire [data_w-1:0]           din_s,
    input  wire [data_w-1:0]           din_w,
    input  wire [data_w-1:0]           din_e,
    input  wire [data_w-1:0]           din_lsu,
    output logic [data_w-1:0]          dout_n,
    output logic [data_w-1:0]          dout_s,
    output logic [data_w-1:0]          dout_w,
    output logic [data_w-1:0]          dout_e,
    output logic [data_w-1:0]          dout_lsu
);
    import pe_pkg::*;

    fu_op_t            opcode;
    sw9_sel_t          xb_n, xb_s, xb_w, xb_e, xb_lsu, xb_a, xb_b;
    sw5_sel_t          sw_r0, sw_r1, sw_r2, sw_r3;
    logic [we_w-1:0]   we;
    logic [data_w-1:0] r0, r1, r2, r3;
    logic [data_w-1:0] op_a, op_b;
    logic [data_w-1:0] fu_result;

    // instruction fields
    assign opcode = fu_op_t'(inst[op_lo +: op_w]);
    assign xb_lsu = sw9_sel_t'(inst[xb_lsu_lo +: sw9_w]);
    assign xb_a   = sw9_sel_t'(inst[xb_a_lo +: sw9_w]);
    assign xb_b   = sw9_sel_t'(inst[xb_b_lo +: sw9_w]);
    assign xb_n   = sw9_sel_t'(inst[xb_n_lo +: sw9_w]);
    assign xb_s   = sw9_sel_t'(inst[xb_s_lo +: sw9_w]);
    assign xb_w   = sw9_sel_t'(inst[xb_w_lo +: sw9_w]);
    assign xb_e   = sw9_sel_t'(inst[xb_e_lo +: sw9_w]);
    assign sw_r0  = sw5_sel_t'(inst[sw_r0_lo +: sw5_w]);
    assign sw_r1  = sw5_sel_t'(inst[sw_r1_lo +: sw5_w]);
    assign sw_r2  = sw5_sel_t'(inst[sw_r2_lo +: sw5_w]);
    assign sw_r3  = sw5_sel_t'(inst[sw_r3_lo +: sw5_w]);
    assign we     = inst[we_lo +: we_w];

    pe_reg_file #(.data_w(data_w)) u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .din_n   (din_n),
        .din_s   (din_s),
        .din_w   (din_w),
        .din_e   (din_e),
        .din_lsu (din_lsu),
        .sel_r0  (sw_r0),
        .sel_r1  (sw_r1),
        .sel_r2  (sw_r2),
        .sel_r3  (sw_r3),
        .we      (we),
        .r0      (r0),
        .r1      (r1),
        .r2      (r2),
        .r3      (r3)
    );

    pe_fu #(.data_w(data_w)) u_fu (
        .clk       (clk),
        .rst_n     (rst_n),
        .opcode    (opcode),
        .op_a      (op_a),
        .op_b      (op_b),
        .fu_result (fu_result)
    );

    pe_crossbar #(.data_w(data_w)) u_crossbar (
        .din_n     (din_n),
        .din_s     (din_s),
        .din_w     (din_w),
        .din_e     (din_e),
        .r0        (r0),
        .r1        (r1),
        .r2        (r2),
        .r3        (r3),
        .fu_result (fu_result),  // fed back as a source
        .sel_n     (xb_n),
        .sel_s     (xb_s),
        .sel_w     (xb_w),
        .sel_e     (xb_e),
        .sel_lsu   (xb_lsu),
        .sel_a     (xb_a),
        .sel_b     (xb_b),
        .dout_n    (dout_n),
        .dout_s    (dout_s),
        .dout_w    (dout_w),
        .dout_e    (dout_e),
        .dout_lsu  (dout_lsu),
        .op_a      (op_a),
        .op_b      (op_b)
    );

endmodule

`default_nettype wire

// File: rtl/pe_crossbar.sv
`timescale 1ns/10ps
`default_nettype none

module pe_crossbar #(
    parameter int data_w = 32
) (
    input  wire [data_w-1:0]       din_n,
    input  wire [data_w-1:0]       din_s,
    input  wire [data_w-1:0]       din_w,
    input  wire [data_w-1:0]       din_e,
    input  wire [data_w-1:0]       r0,
    input  wire [data_w-1:0]       r1,
    input  wire [data_w-1:0]       r2,
    input  wire [data_w-1:0]       r3,
    input  wire [data_w-1:0]       fu_result,
    input  wire pe_pkg::sw9_sel_t  sel_n,
    input  wire pe_pkg::sw9_sel_t  sel_s,
    input  wire pe_pkg::sw9_sel_t  sel_w,
    input  wire pe_pkg::sw9_sel_t  sel_e,
    input  wire pe_pkg::sw9_sel_t  sel_lsu,
    input  wire pe_pkg::sw9_sel_t  sel_a,
    input  wire pe_pkg::sw9_sel_t  sel_b,
    output logic [data_w-1:0]      dout_n,
    output logic [data_w-1:0]      dout_s,
    output logic [data_w-1:0]      dout_w,
    output logic [data_w-1:0]      dout_e,
    output logic [data_w-1:0]      dout_lsu,
    output logic [data_w-1:0]      op_a,
    output logic [data_w-1:0]      op_b
);
    import pe_pkg::*;

    logic [8:0][data_w-1:0] srcs;

    // one nine-way selector, shared by all seven outputs
    function automatic logic [data_w-1:0] sw9_pick(
        input sw9_sel_t               s,
        input logic [8:0][data_w-1:0] src
    );
        case (s)
            src_din_n: sw9_pick = src[0];
            src_din_s: sw9_pick = src[1];
            src_din_w: sw9_pick = src[2];
            src_din_e: sw9_pick = src[3];
            src_r0:    sw9_pick = src[4];
            src_r1:    sw9_pick = src[5];
            src_r2:    sw9_pick = src[6];
            src_r3:    sw9_pick = src[7];
            src_fu:    sw9_pick = src[8];
            default:   sw9_pick = '0;  // codes 9..15
        endcase
    endfunction

    assign srcs = {fu_result, r3, r2, r1, r0, din_e, din_w, din_s, din_n};

    assign dout_n   = sw9_pick(sel_n, srcs);
    assign dout_s   = sw9_pick(sel_s, srcs);
    assign dout_w   = sw9_pick(sel_w, srcs);
    assign dout_e   = sw9_pick(sel_e, srcs);
    assign dout_lsu = sw9_pick(sel_lsu, srcs);
    assign op_a     = sw9_pick(sel_a, srcs);  // operands to the fu
    assign op_b     = sw9_pick(sel_b, srcs);

endmodule

`default_nettype wire

// File: rtl/pe_fu.sv
`timescale 1ns/10ps
`default_nettype none

module pe_fu #(
    parameter int data_w = 32
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire pe_pkg::fu_op_t  opcode,
    input  wire [data_w-1:0]     op_a,
    input  wire [data_w-1:0]     op_b,
    output logic [data_w-1:0]    fu_result
);
    import pe_pkg::*;

    logic [4:0]        shamt;
    logic [data_w-1:0] prod;
    logic [data_w-1:0] fu_next;

    assign shamt = op_b[4:0];
    assign prod  = op_a * op_b;  // low half only

    always_comb begin
        case (opcode)
            op_add: begin
                fu_next = op_a + op_b;
            end
            op_sub: begin
                fu_next = op_a - op_b;
            end
            op_mul: begin
                fu_next = prod;
            end
            op_and: begin
                fu_next = op_a & op_b;
            end
            op_or: begin
                fu_next = op_a | op_b;
            end
            op_xor: begin
                fu_next = op_a ^ op_b;
            end
            op_shl: begin
                fu_next = op_a << shamt;
            end
            op_shr: begin
                fu_next = op_a >> shamt;  // logical
            end
            op_pass_a: begin
                fu_next = op_a;
            end
            op_lt: begin
                // unsigned compare, 1 or 0
                fu_next = {{(data_w-1){1'b0}}, (op_a < op_b)};
            end
            default: begin
                fu_next = '0;
            end
        endcase
    end

    // the single pipeline stage of the pe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fu_result <= '0;
        end else begin
            fu_result <= fu_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pe_reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module pe_reg_file #(
    parameter int data_w = 32
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire [data_w-1:0]       din_n,
    input  wire [data_w-1:0]       din_s,
    input  wire [data_w-1:0]       din_w,
    input  wire [data_w-1:0]       din_e,
    input  wire [data_w-1:0]       din_lsu,
    input  wire pe_pkg::sw5_sel_t  sel_r0,
    input  wire pe_pkg::sw5_sel_t  sel_r1,
    input  wire pe_pkg::sw5_sel_t  sel_r2,
    input  wire pe_pkg::sw5_sel_t  sel_r3,
    input  wire [3:0]              we,
    output logic [data_w-1:0]      r0,
    output logic [data_w-1:0]      r1,
    output logic [data_w-1:0]      r2,
    output logic [data_w-1:0]      r3
);
    import pe_pkg::*;

    logic [4:0][data_w-1:0] srcs;
    sw5_sel_t               sel [4];
    logic [data_w-1:0]      sw_out [4];
    logic [data_w-1:0]      regs [4];

    function automatic logic [data_w-1:0] sw5_pick(
        input sw5_sel_t               s,
        input logic [4:0][data_w-1:0] src
    );
        case (s)
            in_n:    sw5_pick = src[0];
            in_s:    sw5_pick = src[1];
            in_w:    sw5_pick = src[2];
            in_e:    sw5_pick = src[3];
            in_lsu:  sw5_pick = src[4];
            default: sw5_pick = '0;
        endcase
    endfunction

    assign srcs = {din_lsu, din_e, din_w, din_s, din_n};

    assign sel[0] = sel_r0;
    assign sel[1] = sel_r1;
    assign sel[2] = sel_r2;
    assign sel[3] = sel_r3;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            sw_out[i] = sw5_pick(sel[i], srcs);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (we[3-i]) regs[i] <= sw_out[i];  // we[3] is r0
            end
        end
    end

    assign r0 = regs[0];
    assign r1 = regs[1];
    assign r2 = regs[2];
    assign r3 = regs[3];

endmodule

`default_nettype wire

// File: rtl/pe_pkg.sv
`default_nettype none

package pe_pkg;

    localparam int inst_w = 48;

    // field widths inside the instruction
    localparam int op_w  = 4;
    localparam int sw9_w = 4;
    localparam int sw5_w = 3;
    localparam int we_w  = 4;

    // low bit of each instruction field
    localparam int op_lo     = 44;  // 47:44
    localparam int xb_lsu_lo = 40;  // 43:40
    localparam int xb_a_lo   = 36;  // 39:36
    localparam int xb_b_lo   = 32;  // 35:32
    localparam int xb_n_lo   = 28;  // 31:28
    localparam int xb_s_lo   = 24;  // 27:24
    localparam int xb_w_lo   = 20;  // 23:20
    localparam int xb_e_lo   = 16;  // 19:16
    localparam int sw_r0_lo  = 13;  // 15:13
    localparam int sw_r1_lo  = 10;  // 12:10
    localparam int sw_r2_lo  = 7;   // 9:7
    localparam int sw_r3_lo  = 4;   // 6:4
    localparam int we_lo     = 0;   // bit 3 is r0, bit 0 is r3

    // codes 10..15 give zero
    typedef enum logic [op_w-1:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_mul    = 4'd2,
        op_and    = 4'd3,
        op_or     = 4'd4,
        op_xor    = 4'd5,
        op_shl    = 4'd6,
        op_shr    = 4'd7,
        op_pass_a = 4'd8,
        op_lt     = 4'd9
    } fu_op_t;

    // crossbar sources, 9..15 select zero
    typedef enum logic [sw9_w-1:0] {
        src_din_n = 4'd0,
        src_din_s = 4'd1,
        src_din_w = 4'd2,
        src_din_e = 4'd3,
        src_r0    = 4'd4,
        src_r1    = 4'd5,
        src_r2    = 4'd6,
        src_r3    = 4'd7,
        src_fu    = 4'd8
    } sw9_sel_t;

    // input switch sources, 5..7 select zero
    typedef enum logic [sw5_w-1:0] {
        in_n   = 3'd0,
        in_s   = 3'd1,
        in_w   = 3'd2,
        in_e   = 3'd3,
        in_lsu = 3'd4
    } sw5_sel_t;

endpackage

`default_nettype wire
